//--- Makefile
# Verilator build and run of the SM83 core testbench
VERILATOR ?= verilator
TOP ?= sm83CoreTb
FILELIST ?= tb.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- dv/clockGen.sv
// Free-running testbench clock; rstN is released on a falling edge after resetCycles rising edges
`timescale 1ns/1ns

module clockGen #(
	parameter int periodNs = 40,
	parameter int resetCycles = 16
) (
	output logic CLK,
	output logic rstN
);

	initial begin
		CLK = 1'b0;
		forever #(periodNs / 2) CLK = ~CLK;
	end

	initial begin
		rstN = 1'b0;				// Held from time zero
		repeat (resetCycles) @(posedge CLK);
		@(negedge CLK);
		rstN <= 1'b1;				// Same edge as other stimulus
	end

endmodule

//--- dv/sm83CoreTb.sv
// Random program from seed 88 in read-only zero-wait memory. Stores are checked on the bus only
`timescale 1ns/1ns
`include "sm83_defines.svh"

module sm83CoreTb
	import sm83IsaPkg::*;
	import sm83BusPkg::*;
();

	localparam int numBlocks = 40;

	logic CLK;
	logic rstN;
	logic [7:0] rdData = 8'h00;
	busReqS busReq;
	logic loadIr;

	logic [7:0] mem [0:65535];
	logic [15:0] genPc;
	int progInstrs = 0;
	int expStores = 0;
	int cycleLimit = 0;
	int cycleCount = 0;
	int valueErrors = 0;
	int protocolErrors = 0;

	logic [7:0] modelReg [0:7];		// Opcode register order
	flagsS modelF;
	logic [15:0] modelPc;
	logic [15:0] modelHl;
	logic [7:0] modelA;
	logic halted = 1'b0;
	int instrCount = 0;
	int storeCount = 0;
	logic [15:0] expRdAddr;
	logic prevRd = 1'b0;
	logic prevWr = 1'b0;
	logic rdStart;

	clockGen #(.periodNs(40), .resetCycles(16)) clkRst (.CLK(CLK), .rstN(rstN));

	sm83Core sm83Core_i (
		.CLK(CLK),
		.rstN(rstN),
		.rdData(rdData),
		.busReq(busReq),
		.loadIr(loadIr)
	);

	assign rdStart = busReq.rd && !prevRd;	// T1 of a read M-cycle
	assign modelHl = {modelReg[4], modelReg[5]};
	assign modelA = modelReg[7];

	// Reference ALU packed as {z, n, h, c, result}
	function automatic logic [11:0] aluRef(input logic [2:0] op, input logic [7:0] a,
			input logic [7:0] b, input logic carry);
		int ai;
		int bi;
		int ci;
		int full;
		int half;
		logic [7:0] res;
		flagsS f;
		ai = a;
		bi = b;
		ci = (op == 3'd1 || op == 3'd3) ? int'(carry) : 0;	// ADC, SBC
		f = '0;
		res = 8'h00;
		case (op)
			3'd0, 3'd1: begin
				full = ai + bi + ci;
				half = (ai % 16) + (bi % 16) + ci;
				f.h = (half > 15);
				f.c = (full > 255);
				res = full[7:0];
			end
			3'd4: begin
				res = a & b;
				f.h = 1'b1;
			end
			3'd5: res = a ^ b;
			3'd6: res = a | b;
			default: begin				// SUB, SBC, CP
				full = ai - bi - ci;
				half = (ai % 16) - (bi % 16) - ci;
				f.n = 1'b1;
				f.h = (half < 0);
				f.c = (full < 0);
				res = full[7:0];
			end
		endcase
		f.z = (res == 8'h00);
		return {f, (op == 3'd7) ? a : res};
	endfunction

	// Any of B, C, D, E, H, L, A
	function automatic logic [2:0] randomReg();
		logic [2:0] r;
		r = 3'($urandom_range(6, 0));
		return (r == 3'd6) ? 3'd7 : r;
	endfunction

	task automatic emitByte(input logic [7:0] b);
		mem[genPc] = b;
		genPc = genPc + 16'd1;
	endtask

	task automatic emitInstr(input logic [7:0] op);
		emitByte(op);
		progInstrs++;
	endtask

	task automatic buildProgram();
		logic [2:0] op;
		int nOps;
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'(i >> 8) ^ 8'(i * 7) ^ 8'hA5;	// Whole-address fill
		genPc = `SM83_RESET_PC;
		for (int blk = 0; blk < numBlocks; blk++) begin
			emitInstr(8'h3E);				// LD A,d8
			emitByte(8'($urandom));
			emitInstr({2'b00, randomReg(), 3'b110});	// LD r,d8
			emitByte(8'($urandom));
			nOps = $urandom_range(3, 1);
			for (int k = 0; k < nOps; k++) begin
				op = 3'($urandom);
				if ($urandom_range(1, 0) == 0)
					emitInstr({2'b10, op, randomReg()});
				else begin
					emitInstr({2'b11, op, 3'b110});	// Immediate form
					emitByte(8'($urandom));
				end
			end
			// Probe that must leave A alone
			case (blk % 4)
				0: emitInstr({5'b10111, randomReg()});	// CP r
				1: begin
					emitInstr(8'hFE);		// CP d8
					emitByte(8'($urandom));
				end
				2: emitInstr(8'h3C);			// INC A is not decoded
				default: emitInstr(8'h86);		// ADD A,(HL) is not decoded
			endcase
			emitInstr(8'h26);				// LD H,d8
			emitByte({2'b11, 6'($urandom)});		// Well above the program
			emitInstr(8'h2E);				// LD L,d8
			emitByte(8'($urandom));
			emitInstr(8'h77);				// LD (HL),A
			expStores++;
		end
		emitInstr(8'h76);					// HALT
	endtask

	always @(negedge CLK)
		rdData <= busReq.rd ? mem[busReq.addr] : 8'h00;

	// Reference model steps once per fetched opcode
	always @(posedge CLK) begin : refModel
		logic [7:0] op;
		logic [7:0] imm;
		logic [7:0] operand;
		logic [11:0] aluOut;
		logic useImm;
		op = mem[modelPc];
		imm = mem[modelPc + 16'd1];
		useImm = (op[7:6] == 2'b11) && (op[2:0] == 3'b110);
		operand = useImm ? imm : modelReg[op[2:0]];
		aluOut = aluRef(op[5:3], modelReg[7], operand, modelF.c);
		if (!rstN) begin
			for (int i = 0; i < 8; i++)
				modelReg[i] <= 8'h00;
			modelF <= '0;
			modelPc <= `SM83_RESET_PC;
			halted <= 1'b0;
			instrCount <= 0;
		end else if (loadIr) begin
			instrCount <= instrCount + 1;
			if (op == 8'h76)
				halted <= 1'b1;
			if (op[7:6] == 2'b00 && op[2:0] == 3'b110 && op[5:3] != 3'd6) begin
				modelReg[op[5:3]] <= imm;	// LD r,d8
				modelPc <= modelPc + 16'd2;
			end else if (useImm || (op[7:6] == 2'b10 && op[2:0] != 3'd6)) begin
				modelF <= aluOut[11:8];
				if (op[5:3] != 3'd7)
					modelReg[7] <= aluOut[7:0];	// CP keeps A
				modelPc <= modelPc + (useImm ? 16'd2 : 16'd1);
			end else
				modelPc <= modelPc + 16'd1;	// NOP, store, HALT, undecoded
		end
	end

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		prevRd <= rstN && busReq.rd;
		prevWr <= rstN && busReq.wr;
		if (!rstN)
			expRdAddr <= `SM83_RESET_PC;
		else if (rdStart)
			expRdAddr <= expRdAddr + 16'd1;	// Fetch or immediate
		if (rstN && busReq.wr && !prevWr)
			storeCount <= storeCount + 1;
	end

	// Outputs are unknown before the first reset edge
	quietInReset: assert property (@(posedge CLK) !rstN && cycleCount > 0 |->
		!busReq.mreq && !busReq.rd && !busReq.wr && !loadIr)
		else begin
			protocolErrors++;
			$display("Bus strobe or loadIr active during reset at %0t", $time);
		end

	firstFetch: assert property (@(posedge CLK) $rose(rstN) |=>
		busReq.mreq && busReq.rd && !busReq.wr && busReq.addr == `SM83_RESET_PC)
		else begin
			valueErrors++;
			$display("[FAIL] %0t: first bus cycle rd %b wr %b addr %h", $time,
				$sampled(busReq.rd), $sampled(busReq.wr), $sampled(busReq.addr));
		end

	readOrder: assert property (@(posedge CLK) disable iff (!rstN)
		rdStart |-> busReq.addr == expRdAddr)
		else begin
			valueErrors++;
			$display("[FAIL] %0t: read at %h, expected %h", $time,
				$sampled(busReq.addr), $sampled(expRdAddr));
		end

	fetchAddr: assert property (@(posedge CLK) disable iff (!rstN)
		loadIr |-> busReq.addr == modelPc)
		else begin
			valueErrors++;
			$display("[FAIL] %0t: opcode fetched at %h, expected %h", $time,
				$sampled(busReq.addr), $sampled(modelPc));
		end

	onePulse: assert property (@(posedge CLK) disable iff (!rstN) loadIr |=> !loadIr)
		else begin
			protocolErrors++;
			$display("loadIr stayed high for two cycles at %0t", $time);
		end

	storeData: assert property (@(posedge CLK) disable iff (!rstN)
		busReq.wr |-> busReq.addr == modelHl && busReq.wrData == modelA)
		else begin
			valueErrors++;
			$display("[FAIL] %0t: store %h to %h, expected %h to %h", $time,
				$sampled(busReq.wrData), $sampled(busReq.addr),
				$sampled(modelA), $sampled(modelHl));
		end

	haltQuiet: assert property (@(posedge CLK) halted |-> !busReq.mreq)
		else begin
			protocolErrors++;
			$display("Memory request after HALT at %0t", $time);
		end

	rdWrApart: assert property (@(posedge CLK) cycleCount > 0 |-> !(busReq.rd && busReq.wr))
		else begin
			protocolErrors++;
			$display("Read and write strobes high together at %0t", $time);
		end

	initial begin
		void'($urandom(88));
		buildProgram();
		cycleLimit = progInstrs * 2 * `SM83_SLOTS + 16 + 200;	// Two M-cycles worst case
		while (!halted && cycleCount < cycleLimit)
			@(negedge CLK);
		if (!halted) begin
			protocolErrors++;
			$display("Timeout: HALT not reached within %0d cycles", cycleLimit);
		end else begin
			repeat (40) @(negedge CLK);	// Bus must stay idle
			if (instrCount != progInstrs) begin
				valueErrors++;
				$display("[FAIL] %0t: %0d loadIr pulses for %0d instructions", $time,
					instrCount, progInstrs);
			end
			if (storeCount != expStores) begin
				valueErrors++;
				$display("[FAIL] %0t: %0d store cycles, expected %0d", $time,
					storeCount, expStores);
			end
		end
		$display("Error counts: value %0d, protocol %0d", valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- tb.f
+incdir+verilog
verilog/sm83IsaPkg.sv
verilog/sm83BusPkg.sv
verilog/sm83Decoder.sv
verilog/sm83Sequencer.sv
verilog/sm83Alu.sv
verilog/sm83RegFile.sv
verilog/sm83Core.sv
dv/clockGen.sv
dv/sm83CoreTb.sv

//--- verilog/sm83Alu.sv
// Combinational 8-bit ALU with SM83 flag rules. Only C of flagsIn is read
`timescale 1ns/1ns
`include "sm83_defines.svh"

module sm83Alu
	import sm83IsaPkg::*;
(
	input aluOpE aluOp,
	input logic [`SM83_DATA_W-1:0] opA,	// Always A
	input logic [`SM83_DATA_W-1:0] opB,	// Register or immediate
	input flagsS flagsIn,
	output logic [`SM83_DATA_W-1:0] result,
	output flagsS flagsOut
);

	logic cin;
	logic [`SM83_DATA_W:0] wide;	// Bit 8 is carry or borrow
	logic [4:0] nibble;		// Bit 4 is half carry or borrow
	logic [`SM83_DATA_W-1:0] value;	// Before CP substitution

	always_comb begin
		cin = 1'b0;
		wide = '0;
		nibble = '0;
		value = opA;
		flagsOut = '0;
		unique case (aluOp)
			aluAdd, aluAdc: begin
				cin = (aluOp == aluAdc) && flagsIn.c;
				wide = {1'b0, opA} + {1'b0, opB} + {8'd0, cin};
				nibble = {1'b0, opA[3:0]} + {1'b0, opB[3:0]} + {4'd0, cin};
				value = wide[`SM83_DATA_W-1:0];
				flagsOut.h = nibble[4];
				flagsOut.c = wide[`SM83_DATA_W];
			end
			aluSub, aluSbc, aluCp: begin
				cin = (aluOp == aluSbc) && flagsIn.c;	// Borrow in
				wide = {1'b0, opA} - {1'b0, opB} - {8'd0, cin};
				nibble = {1'b0, opA[3:0]} - {1'b0, opB[3:0]} - {4'd0, cin};
				value = wide[`SM83_DATA_W-1:0];
				flagsOut.n = 1'b1;
				flagsOut.h = nibble[4];
				flagsOut.c = wide[`SM83_DATA_W];
			end
			aluAnd: begin
				value = opA & opB;
				flagsOut.h = 1'b1;	// SM83 quirk
			end
			aluXor: value = opA ^ opB;
			aluOr: value = opA | opB;
			default: value = opA;
		endcase
		flagsOut.z = (value == '0);	// CP uses the difference
		result = (aluOp == aluCp) ? opA : value;
	end

endmodule

//--- verilog/sm83BusPkg.sv
// Bus and timing types. Zero-wait memory only, so no ready or wait fields
`include "sm83_defines.svh"

package sm83BusPkg;
	import sm83IsaPkg::*;

	// Slot within one M-cycle
	typedef enum logic [1:0] {
		slotT1,
		slotT2,
		slotT3,
		slotT4
	} slotE;

	// Memory request driven by the core
	typedef struct packed {
		logic [`SM83_ADDR_W-1:0] addr;		// PC or HL
		logic [`SM83_DATA_W-1:0] wrData;	// Valid while wr
		logic rd;
		logic wr;
		logic mreq;				// Whole bus M-cycle
	} busReqS;

	// Decoder control word
	typedef struct packed {
		logic needImm;		// Extra read M-cycle
		logic doAlu;
		logic doLoad;		// LD r,d8
		logic doStore;		// LD (HL),A
		logic doHalt;
		aluOpE aluOp;
		regSelE dst;		// Load target
		logic writeA;		// Clear for CP
	} ctrlS;

endpackage

//--- verilog/sm83Core.sv
// Core top level on one CLK. Split read and write data. No interrupts, wait states or 16-bit ops
`timescale 1ns/1ns
`include "sm83_defines.svh"

module sm83Core
	import sm83IsaPkg::*;
	import sm83BusPkg::*;
(
	input logic CLK,
	input logic rstN,				// Synchronous
	input logic [`SM83_DATA_W-1:0] rdData,
	output busReqS busReq,
	output logic loadIr				// Opcode fetched
);

	opcodeU opcode;
	ctrlS ctrl;
	logic [`SM83_DATA_W-1:0] immData;
	logic [`SM83_DATA_W-1:0] srcVal;
	logic [`SM83_DATA_W-1:0] aVal;
	logic [`SM83_DATA_W-1:0] aluResult;
	logic [`SM83_ADDR_W-1:0] hl;
	logic wbStrobe;
	flagsS flags;
	flagsS aluFlags;

	sm83Sequencer seq (
		.CLK(CLK),
		.rstN(rstN),
		.rdData(rdData),
		.ctrl(ctrl),
		.hl(hl),
		.aVal(aVal),
		.opcode(opcode),
		.immData(immData),
		.wbStrobe(wbStrobe),
		.busReq(busReq),
		.loadIr(loadIr)
	);

	sm83Decoder dec (
		.opcode(opcode),
		.ctrl(ctrl)
	);

	sm83Alu alu (
		.aluOp(ctrl.aluOp),
		.opA(aVal),
		.opB(srcVal),
		.flagsIn(flags),
		.result(aluResult),
		.flagsOut(aluFlags)
	);

	sm83RegFile regs (
		.CLK(CLK),
		.rstN(rstN),
		.ctrl(ctrl),
		.wbStrobe(wbStrobe),
		.aluResult(aluResult),
		.aluFlags(aluFlags),
		.immData(immData),
		.srcSel(opcode.aluView.src),	// Immediate when 110
		.srcVal(srcVal),
		.aVal(aVal),
		.flags(flags),
		.hl(hl)
	);

endmodule

//--- verilog/sm83Decoder.sv
// Combinational opcode decoder. Opcodes outside the subset give an all-zero control word
`timescale 1ns/1ns

module sm83Decoder
	import sm83IsaPkg::*;
	import sm83BusPkg::*;
(
	input opcodeU opcode,	// Latched IR
	output ctrlS ctrl
);

	always_comb begin
		ctrl = '0;	// NOP by default
		unique case (opcode.aluView.group)
			2'b00: begin
				// LD r,d8 column without LD (HL),d8
				if (opcode.ldView.low == 3'b110 && opcode.ldView.dst != regHlMem) begin
					ctrl.needImm = 1'b1;
					ctrl.doLoad = 1'b1;
					ctrl.dst = opcode.ldView.dst;
				end
			end
			2'b01: begin
				// Only the (HL) row is decoded here
				if (opcode.ldView.dst == regHlMem) begin
					ctrl.doHalt = (opcode.ldView.low == 3'b110);	// 0x76
					ctrl.doStore = (opcode.ldView.low == 3'b111);	// 0x77
				end
			end
			2'b10: begin
				// Register source without the (HL) form
				if (opcode.aluView.src != regHlMem) begin
					ctrl.doAlu = 1'b1;
					ctrl.aluOp = opcode.aluView.aluOp;
					ctrl.writeA = (opcode.aluView.aluOp != aluCp);
				end
			end
			2'b11: begin
				// Immediate column xx110
				if (opcode.aluView.src == regHlMem) begin
					ctrl.needImm = 1'b1;
					ctrl.doAlu = 1'b1;
					ctrl.aluOp = opcode.aluView.aluOp;
					ctrl.writeA = (opcode.aluView.aluOp != aluCp);
				end
			end
			default: ctrl = '0;
		endcase
	end

	// Regfile write port takes ALU or load data but never both
	always_comb begin
		assert (!(ctrl.doAlu && ctrl.doLoad))
			else $error("Decoder set doAlu and doLoad for opcode %h", opcode);
	end

endmodule

//--- verilog/sm83IsaPkg.sv
// Instruction-set types for the SM83 subset. Field order follows the opcode bit layout
package sm83IsaPkg;

	// ALU operation in opcode order
	typedef enum logic [2:0] {
		aluAdd,
		aluAdc,
		aluSub,
		aluSbc,
		aluAnd,
		aluXor,
		aluOr,
		aluCp
	} aluOpE;

	// Register select in opcode order
	typedef enum logic [2:0] {
		regB,
		regC,
		regD,
		regE,
		regH,
		regL,
		regHlMem,	// (HL) operand or immediate marker
		regA
	} regSelE;

	// Opcode seen as an ALU op
	typedef struct packed {
		logic [1:0] group;	// Bits 7:6
		aluOpE aluOp;		// Bits 5:3
		regSelE src;		// Bits 2:0
	} aluViewS;

	// Opcode seen as a load
	typedef struct packed {
		logic [1:0] group;	// Bits 7:6
		regSelE dst;		// Bits 5:3
		logic [2:0] low;	// Bits 2:0
	} ldViewS;

	// One opcode byte with two decodings
	typedef union packed {
		aluViewS aluView;
		ldViewS ldView;
	} opcodeU;

	// Flag nibble held in the upper bits of F
	typedef struct packed {
		logic z;
		logic n;
		logic h;
		logic c;
	} flagsS;

endpackage

//--- verilog/sm83RegFile.sv
// Registers B to A plus F. Source select regHlMem returns the immediate byte
`timescale 1ns/1ns
`include "sm83_defines.svh"

module sm83RegFile
	import sm83IsaPkg::*;
	import sm83BusPkg::*;
(
	input logic CLK,
	input logic rstN,
	input ctrlS ctrl,
	input logic wbStrobe,
	input logic [`SM83_DATA_W-1:0] aluResult,
	input flagsS aluFlags,
	input logic [`SM83_DATA_W-1:0] immData,
	input regSelE srcSel,			// Opcode bits 2:0
	output logic [`SM83_DATA_W-1:0] srcVal,	// ALU operand B
	output logic [`SM83_DATA_W-1:0] aVal,
	output flagsS flags,
	output logic [`SM83_ADDR_W-1:0] hl
);

	logic [`SM83_DATA_W-1:0] gpr [0:7];	// Entry 6 never written
	flagsS fReg;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < 8; i++)
				gpr[i] <= '0;
			fReg <= '0;
		end else if (wbStrobe) begin
			if (ctrl.doLoad)
				gpr[ctrl.dst] <= immData;	// LD r,d8
			if (ctrl.doAlu) begin
				fReg <= aluFlags;
				if (ctrl.writeA)
					gpr[regA] <= aluResult;	// CP skips
			end
		end
	end

	assign srcVal = (srcSel == regHlMem) ? immData : gpr[srcSel];
	assign aVal = gpr[regA];
	assign flags = fReg;
	assign hl = {gpr[regH], gpr[regL]};

	// Decoder must never route a load to the (HL) slot
	noHlMemWrite: assert property (@(posedge CLK) disable iff (!rstN)
		wbStrobe && ctrl.doLoad |-> ctrl.dst != regHlMem)
		else $error("Write-back aimed at HL-memory select");

endmodule

//--- verilog/sm83Sequencer.sv
// Slot counter and M-cycle FSM. Zero-wait memory assumed; halted core leaves only by reset
`timescale 1ns/1ns
`include "sm83_defines.svh"

module sm83Sequencer
	import sm83IsaPkg::*;
	import sm83BusPkg::*;
(
	input logic CLK,
	input logic rstN,
	input logic [`SM83_DATA_W-1:0] rdData,
	input ctrlS ctrl,			// From decoder
	input logic [`SM83_ADDR_W-1:0] hl,	// Store address
	input logic [`SM83_DATA_W-1:0] aVal,	// Store data
	output opcodeU opcode,
	output logic [`SM83_DATA_W-1:0] immData,
	output logic wbStrobe,			// Last T4 of instruction
	output busReqS busReq,
	output logic loadIr
);

	typedef enum logic [2:0] {
		mBoot,		// Idle M-cycle out of reset
		mFetch,
		mImm,
		mStore,
		mHalt
	} mStateE;

	slotE slot;
	mStateE mState;
	logic [`SM83_ADDR_W-1:0] pc;
	opcodeU ir;
	logic [`SM83_DATA_W-1:0] immQ;
	logic mEnd;	// T4 of any M-cycle
	logic rdCycle;

	assign mEnd = (slot == slotE'(`SM83_SLOTS - 1));
	assign rdCycle = (mState == mFetch) || (mState == mImm);

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			slot <= slotE'(`SM83_SLOTS - 1);	// Wraps to T1 on release
			mState <= mBoot;
			pc <= `SM83_RESET_PC;
			ir <= '0;				// NOP
		end else begin
			slot <= slotE'(slot + 2'd1);
			if (mState == mFetch && slot == slotT3)
				ir <= rdData;			// Sample at end of T3
			if (mEnd) begin
				unique case (mState)
					mBoot: mState <= mFetch;
					mFetch: begin
						pc <= pc + 1'b1;
						if (ctrl.doHalt)
							mState <= mHalt;
						else if (ctrl.needImm)
							mState <= mImm;
						else if (ctrl.doStore)
							mState <= mStore;
						else
							mState <= mFetch;
					end
					mImm: begin
						pc <= pc + 1'b1;	// Operand consumed
						mState <= mFetch;
					end
					mStore: mState <= mFetch;
					default: mState <= mHalt;	// Stuck until reset
				endcase
			end
		end
	end

	// Immediate byte read at end of T3
	always_ff @(posedge CLK) begin
		if (mState == mImm && slot == slotT3)
			immQ <= rdData;
	end

	always_comb begin
		busReq.addr = (mState == mStore) ? hl : pc;
		busReq.wrData = (mState == mStore) ? aVal : '0;
		busReq.mreq = rdCycle || (mState == mStore);
		busReq.rd = rdCycle && !mEnd;			// T1 to T3
		busReq.wr = (mState == mStore) && !mEnd;
	end

	assign loadIr = (mState == mFetch) && mEnd;
	assign wbStrobe = mEnd && ((mState == mFetch && !ctrl.needImm) || mState == mImm);
	assign opcode = ir;
	assign immData = immQ;

	rdWrExclusive: assert property (@(posedge CLK) !(busReq.rd && busReq.wr))
		else $error("rd and wr high together");

	// Pulse closes a three-slot read of the same address
	loadIrInFetchT4: assert property (@(posedge CLK) disable iff (!rstN)
		loadIr |-> slot == slotT4 && !busReq.rd && $past(busReq.rd, 3) && $stable(busReq.addr))
		else $error("loadIr outside T4 of a fetch");

endmodule

//--- verilog/sm83_defines.svh
// Bus widths, reset PC and slot count for the core. Package types assume these exact widths
`ifndef SM83_DEFINES_SVH
`define SM83_DEFINES_SVH

// Address bus width in bits
`define SM83_ADDR_W 16

// Data bus and register width in bits
`define SM83_DATA_W 8

// First fetch address after reset
`define SM83_RESET_PC 16'h0000

// CLK cycles per M-cycle
`define SM83_SLOTS 4

`endif
